/* ddc_pkg.sv */
package ddc_pkg;

	typedef logic signed [15:0] sample_t;	// adc, mixer and decimator samples
	typedef logic [31:0] phase_t;
	typedef logic [31:0] freq_t;		// nco tuning word
	typedef logic signed [18:0] acc_t;	// holds a full group sum

	// samples per output pair
	localparam int DECIM = 8;
	localparam int DECIM_SHIFT = 3;		// log2 of DECIM

	// one period of sin(2*pi*k/16) in Q1.15
	// the peak is clipped to 32767, the trough kept symmetric
	localparam sample_t SINE_TABLE [16] = '{
		16'sd0,
		16'sd12540,
		16'sd23170,
		16'sd30274,
		16'sd32767,
		16'sd30274,
		16'sd23170,
		16'sd12540,
		16'sd0,
		-16'sd12540,
		-16'sd23170,
		-16'sd30274,
		-16'sd32767,
		-16'sd30274,
		-16'sd23170,
		-16'sd12540
	};

	localparam int COS_OFFSET = 4;	// quarter turn of the table

endpackage

/* fx2_pkg.sv */
package fx2_pkg;

	// pair buffer between decimator and endpoint
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = 4;

	typedef logic [31:0] iq_word_t;	// I in [31:16], Q in [15:0]

	// slave fifo address pins
	typedef logic [1:0] ep_addr_t;
	localparam ep_addr_t EP6_ADDR = 2'b10;	// in endpoint towards the host

	// endpoint writer, one pair per pass
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE_I,
		ST_WRITE_Q
	} writer_state_t;

endpackage

/* nco_mixer.sv */
module nco_mixer (
	input  logic             ENC_CLK,
	input  logic             i_rst_n,
	input  ddc_pkg::freq_t   i_freq,
	input  ddc_pkg::sample_t i_adc,
	output ddc_pkg::sample_t o_mix_i,
	output ddc_pkg::sample_t o_mix_q,
	output logic             o_mix_valid
);
	import ddc_pkg::*;

	phase_t phase_q;
	logic [3:0] sin_idx;
	logic [3:0] cos_idx;

	// stage 1 registers, sample and its table entries
	sample_t adc_q;
	sample_t sin_q;
	sample_t cos_q;

	// full width products
	logic signed [31:0] prod_i;
	logic signed [31:0] prod_q;

	logic [1:0] valid_sr;

	// coarse phase picks the table entry
	assign sin_idx = phase_q[31:28];
	assign cos_idx = sin_idx + 4'(COS_OFFSET);	// wraps mod 16

	// phase accumulator
	always_ff @(posedge ENC_CLK) begin
		if (!i_rst_n) begin
			phase_q <= '0;
		end else begin
			phase_q <= phase_q + i_freq;
		end
	end

	// lookup stage
	always_ff @(posedge ENC_CLK) begin
		adc_q <= i_adc;
		sin_q <= SINE_TABLE[sin_idx];
		cos_q <= SINE_TABLE[cos_idx];
	end

	assign prod_i = adc_q * cos_q;
	assign prod_q = adc_q * sin_q;

	// multiply stage, back to Q1.15 by dropping 15 fraction bits
	always_ff @(posedge ENC_CLK) begin
		o_mix_i <= sample_t'(prod_i >>> 15);
		o_mix_q <= sample_t'(prod_q >>> 15);
	end

	// fills with ones as the pipeline primes
	always_ff @(posedge ENC_CLK) begin
		if (!i_rst_n) begin
			valid_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[0], 1'b1};
		end
	end

	assign o_mix_valid = valid_sr[1];	// two stages deep

endmodule

/* boxcar_decimator.sv */
module boxcar_decimator (
	input  logic             ENC_CLK,
	input  logic             i_rst_n,
	input  ddc_pkg::sample_t i_mix_i,
	input  ddc_pkg::sample_t i_mix_q,
	input  logic             i_mix_valid,
	output ddc_pkg::sample_t o_dec_i,
	output ddc_pkg::sample_t o_dec_q,
	output logic             o_dec_stb
);
	import ddc_pkg::*;

	logic [DECIM_SHIFT-1:0] grp_cnt;	// position inside the group
	logic grp_last;
	logic grp_done;			// group sum is complete

	acc_t acc_i;
	acc_t acc_q;

	assign grp_last = (grp_cnt == DECIM_SHIFT'(DECIM - 1));

	// group counter and dump strobe
	always_ff @(posedge ENC_CLK) begin
		if (!i_rst_n) begin
			grp_cnt <= '0;
			grp_done <= 1'b0;
			o_dec_stb <= 1'b0;
		end else begin
			grp_done <= i_mix_valid && grp_last;
			o_dec_stb <= grp_done;
			if (i_mix_valid) begin
				grp_cnt <= grp_cnt + 1'b1;	// natural wrap after DECIM
			end
		end
	end

	// integrate, restarting on the first sample of each group
	always_ff @(posedge ENC_CLK) begin
		if (i_mix_valid) begin
			if (grp_cnt == '0) begin
				acc_i <= acc_t'(i_mix_i);
				acc_q <= acc_t'(i_mix_q);
			end else begin
				acc_i <= acc_i + acc_t'(i_mix_i);
				acc_q <= acc_q + acc_t'(i_mix_q);
			end
		end
	end

	// dump the finished sums, scaled back by DECIM
	always_ff @(posedge ENC_CLK) begin
		if (grp_done) begin
			o_dec_i <= sample_t'(acc_i >>> DECIM_SHIFT);
			o_dec_q <= sample_t'(acc_q >>> DECIM_SHIFT);
		end
	end

endmodule

/* iq_fifo.sv */
module iq_fifo (
	input  logic              ENC_CLK,
	input  logic              i_rst_n,
	input  logic              i_wr_stb,
	input  ddc_pkg::sample_t  i_wr_i,
	input  ddc_pkg::sample_t  i_wr_q,
	input  logic              i_rd_stb,
	output fx2_pkg::iq_word_t o_rd_data,
	output logic              o_empty,
	output logic              o_overflow
);
	import fx2_pkg::*;

	iq_word_t mem [FIFO_DEPTH];

	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0] count;	// one extra bit to tell full from empty

	logic full;
	logic wr_en;
	logic rd_en;

	assign full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
	assign o_empty = (count == '0);

	// a pair offered while full is lost
	assign wr_en = i_wr_stb && !full;
	assign rd_en = i_rd_stb && !o_empty;

	// head entry shown ahead of the pop
	assign o_rd_data = mem[rd_ptr];

	always_ff @(posedge ENC_CLK) begin
		if (wr_en) begin
			mem[wr_ptr] <= {i_wr_i, i_wr_q};
		end
	end

	always_ff @(posedge ENC_CLK) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			// occupancy, unchanged on push plus pop
			if (wr_en && !rd_en) begin
				count <= count + 1'b1;
			end else if (rd_en && !wr_en) begin
				count <= count - 1'b1;
			end

			if (i_wr_stb && full) begin
				o_overflow <= 1'b1;	// sticky until reset
			end
		end
	end

endmodule

/* ep6_writer.sv */
module ep6_writer (
	input  logic              ENC_CLK,
	input  logic              i_rst_n,
	input  logic              i_empty,
	input  fx2_pkg::iq_word_t i_rd_data,
	input  logic              i_flagb,
	output logic              o_rd_stb,
	output logic [15:0]       o_fd,
	output logic              o_slwr_n,
	output fx2_pkg::ep_addr_t o_fifo_adr
);
	import fx2_pkg::*;

	writer_state_t state;
	logic [15:0] q_hold;	// Q word waits here while I goes out

	assign o_fifo_adr = EP6_ADDR;	// only ever talk to EP6

	// i_flagb is the active low full flag, so no strobe while it is low
	assign o_slwr_n = !(((state == ST_WRITE_I) || (state == ST_WRITE_Q)) && i_flagb);

	always_ff @(posedge ENC_CLK) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
			o_rd_stb <= 1'b0;
			o_fd <= '0;
		end else begin
			o_rd_stb <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (!i_empty && i_flagb) begin
						o_rd_stb <= 1'b1;	// pop lands at end of ST_READ
						state <= ST_READ;
					end
				end
				ST_READ: begin
					o_fd <= i_rd_data[31:16];
					state <= ST_WRITE_I;
				end
				ST_WRITE_I: begin
					// also holds here if the endpoint fills during the read
					if (i_flagb) begin
						o_fd <= q_hold;
						state <= ST_WRITE_Q;
					end
				end
				ST_WRITE_Q: begin
					if (i_flagb) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// latched together with I while the head is still valid
	always_ff @(posedge ENC_CLK) begin
		if (state == ST_READ) begin
			q_hold <= i_rd_data[15:0];
		end
	end

endmodule

/* ozy_rx_top.sv */
module ozy_rx_top (
	input  logic              ENC_CLK,
	input  logic              i_rst_n,
	input  ddc_pkg::sample_t  i_adc,
	input  logic              i_freq_wr,
	input  ddc_pkg::freq_t    i_freq_data,
	input  logic              i_flagb,
	output logic [15:0]       o_fd,
	output logic              o_slwr_n,
	output fx2_pkg::ep_addr_t o_fifo_adr,
	output logic              o_overflow
);
	import ddc_pkg::*;
	import fx2_pkg::*;

	freq_t freq_q;	// tuning word from the host

	sample_t mix_i;
	sample_t mix_q;
	logic mix_valid;

	sample_t dec_i;
	sample_t dec_q;
	logic dec_stb;

	iq_word_t rd_data;
	logic fifo_empty;
	logic rd_stb;

	// loaded on the strobe, used by the next phase step
	always_ff @(posedge ENC_CLK) begin
		if (!i_rst_n) begin
			freq_q <= '0;
		end else if (i_freq_wr) begin
			freq_q <= i_freq_data;
		end
	end

	nco_mixer nco_mixer_i (.ENC_CLK(ENC_CLK), .i_rst_n(i_rst_n), .i_freq(freq_q),
		.i_adc(i_adc), .o_mix_i(mix_i), .o_mix_q(mix_q), .o_mix_valid(mix_valid));

	boxcar_decimator boxcar_decimator_i (.ENC_CLK(ENC_CLK), .i_rst_n(i_rst_n),
		.i_mix_i(mix_i), .i_mix_q(mix_q), .i_mix_valid(mix_valid),
		.o_dec_i(dec_i), .o_dec_q(dec_q), .o_dec_stb(dec_stb));

	iq_fifo iq_fifo_i (.ENC_CLK(ENC_CLK), .i_rst_n(i_rst_n), .i_wr_stb(dec_stb),
		.i_wr_i(dec_i), .i_wr_q(dec_q), .i_rd_stb(rd_stb), .o_rd_data(rd_data),
		.o_empty(fifo_empty), .o_overflow(o_overflow));

	ep6_writer ep6_writer_i (.ENC_CLK(ENC_CLK), .i_rst_n(i_rst_n), .i_empty(fifo_empty),
		.i_rd_data(rd_data), .i_flagb(i_flagb), .o_rd_stb(rd_stb), .o_fd(o_fd),
		.o_slwr_n(o_slwr_n), .o_fifo_adr(o_fifo_adr));

endmodule

/* tb_ozy_rx_sva.sv */
module ozy_rx_sva (
	input logic                   ENC_CLK,
	input logic                   i_rst_n,
	input logic                   i_flagb,
	input logic                   i_empty,
	input logic                   i_rd_stb,
	input logic                   i_slwr_n,
	input fx2_pkg::writer_state_t i_state
);
	import fx2_pkg::*;

	// I word held back while the endpoint is full
	a_i_word_held: assert property (@(posedge ENC_CLK) disable iff (!i_rst_n)
		(i_state == ST_WRITE_I && !i_flagb) |=> (i_state == ST_WRITE_I))
		else $error("I word skipped with i_flagb low");

	// every I word is followed by its Q word
	a_q_after_i: assert property (@(posedge ENC_CLK) disable iff (!i_rst_n)
		(i_state == ST_WRITE_I && !i_slwr_n) |=> (i_state == ST_WRITE_Q))
		else $error("I word written without moving on to the Q word");

	// FIFO read side, seen from the writer
	a_no_pop_empty: assert property (@(posedge ENC_CLK) disable iff (!i_rst_n)
		i_rd_stb |-> !i_empty)
		else $error("pop from an empty FIFO");

endmodule

bind ep6_writer ozy_rx_sva sva_i (.ENC_CLK(ENC_CLK), .i_rst_n(i_rst_n), .i_flagb(i_flagb),
	.i_empty(i_empty), .i_rd_stb(o_rd_stb), .i_slwr_n(o_slwr_n), .i_state(state));

/* tb_ozy_rx.sv */
module tb_ozy_rx;
	import ddc_pkg::*;
	import fx2_pkg::*;

	logic ENC_CLK;
	logic i_rst_n;
	sample_t i_adc;
	logic i_freq_wr;
	freq_t i_freq_data;
	logic i_flagb;
	logic [15:0] o_fd;
	logic o_slwr_n;
	ep_addr_t o_fifo_adr;
	logic o_overflow;

	integer seed = 32'hb7c274fe;

	// reference model state
	phase_t m_phase;
	freq_t m_freq;
	int m_cnt;
	int m_sum_i;
	int m_sum_q;
	logic [15:0] exp_q [$];	// expected words, I then Q
	logic [15:0] exp_word;

	int words_seen = 0;
	int word_limit = 32'h7fffffff;	// words past this are not compared
	int mon_errors = 0;
	int chk_errors = 0;
	int errs_at_start;
	int words_at_start;
	int tests_run = 0;
	int tests_failed = 0;

	ozy_rx_top dut_i (.ENC_CLK(ENC_CLK), .i_rst_n(i_rst_n), .i_adc(i_adc),
		.i_freq_wr(i_freq_wr), .i_freq_data(i_freq_data), .i_flagb(i_flagb),
		.o_fd(o_fd), .o_slwr_n(o_slwr_n), .o_fifo_adr(o_fifo_adr), .o_overflow(o_overflow));

	initial begin
		ENC_CLK = 1'b0;
		forever #4 ENC_CLK = ~ENC_CLK;
	end

	// sin(2*pi*k/16) in Q1.15, rounded, kept inside +-32767
	function automatic int sine_q15(input int k);
		real v;
		int r;
		v = $sin(6.283185307179586 * real'(k) / 16.0) * 32768.0;
		if (v >= 0.0) begin
			r = $rtoi(v + 0.5);
		end else begin
			r = -$rtoi(0.5 - v);
		end
		if (r > 32767) begin
			r = 32767;
		end
		if (r < -32767) begin
			r = -32767;
		end
		return r;
	endfunction

	function automatic sample_t mix_product(input sample_t adc, input int coef);
		int p;
		p = int'(adc) * coef;
		return sample_t'(p >>> 15);	// back to Q1.15, low 16 bits kept
	endfunction

	// one clock edge of the receive chain, from the inputs held for that edge
	task automatic model_step();
		int idx;
		if (!i_rst_n) begin
			m_phase = '0;
			m_freq = '0;
			m_cnt = 0;
			m_sum_i = 0;
			m_sum_q = 0;
		end else begin
			idx = int'(m_phase[31:28]);
			m_sum_i += int'(mix_product(i_adc, sine_q15((idx + COS_OFFSET) % 16)));
			m_sum_q += int'(mix_product(i_adc, sine_q15(idx)));
			m_cnt++;
			if (m_cnt == DECIM) begin
				exp_q.push_back(16'(m_sum_i >>> DECIM_SHIFT));
				exp_q.push_back(16'(m_sum_q >>> DECIM_SHIFT));
				m_cnt = 0;
				m_sum_i = 0;
				m_sum_q = 0;
			end
			m_phase += m_freq;	// old tuning word steps this edge
			if (i_freq_wr) begin
				m_freq = i_freq_data;
			end
		end
	endtask

	// mid-cycle: a low o_slwr_n here is a word taken on the next edge
	always @(negedge ENC_CLK) begin
		if (i_rst_n && !o_slwr_n) begin
			if (!i_flagb) begin
				$display("[ERROR] o_slwr_n=%h while i_flagb=%h", o_slwr_n, i_flagb);
				mon_errors++;
			end
			// endpoint address on every write
			if (o_fifo_adr !== 2'b10) begin
				$display("[ERROR] o_fifo_adr expected %h got %h", 2'b10, o_fifo_adr);
				mon_errors++;
			end
			if (words_seen < word_limit) begin
				if (exp_q.size() == 0) begin
					$display("word written on o_fd before the model produced one");
					mon_errors++;
				end else begin
					exp_word = exp_q.pop_front();
					if (o_fd !== exp_word) begin
						$display("[ERROR] o_fd word %0d expected %h got %h",
							words_seen, exp_word, o_fd);
						mon_errors++;
					end
				end
			end
			words_seen++;
		end
		model_step();
	end

	task automatic drive_cycle(input logic flag);
		@(posedge ENC_CLK);
		#1;
		i_adc = sample_t'($random(seed));
		i_flagb = flag;
		i_freq_wr = 1'b0;
	endtask

	task automatic load_freq(input freq_t f);
		@(posedge ENC_CLK);
		#1;
		i_adc = sample_t'($random(seed));
		i_freq_data = f;
		i_freq_wr = 1'b1;	// single cycle strobe
	endtask

	task automatic apply_reset();
		i_rst_n = 1'b0;
		repeat (8) drive_cycle(1'b1);
		exp_q.delete();
		word_limit = 32'h7fffffff;
		i_rst_n = 1'b1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s expected %h got %h", name, exp, got);
			chk_errors++;
		end
	endtask

	// steady state leaves at most the pair still inside the DUT pipeline
	task automatic wait_caught_up();
		int t;
		t = 0;
		while (exp_q.size() > 2 && t < 400) begin
			drive_cycle(1'b1);
			t++;
		end
		if (exp_q.size() > 2) begin
			$display("timeout, %0d expected words never reached o_fd", exp_q.size());
			chk_errors++;
		end
	endtask

	task automatic start_test();
		errs_at_start = mon_errors + chk_errors;
		words_at_start = words_seen;
	endtask

	task automatic finish_test(input string name);
		int n;
		n = mon_errors + chk_errors - errs_at_start;
		tests_run++;
		if (n != 0) begin
			tests_failed++;
		end
		$display("%s: %0d words, %0d errors", name, words_seen - words_at_start, n);
	endtask

	initial begin
		int t;
		i_rst_n = 1'b0;
		i_adc = '0;
		i_freq_wr = 1'b0;
		i_freq_data = '0;
		i_flagb = 1'b1;

		// reset values, nothing out before the first group
		start_test();
		apply_reset();
		check_value("o_slwr_n", 32'(o_slwr_n), 32'h1);
		check_value("o_overflow", 32'(o_overflow), 32'h0);
		check_value("o_fifo_adr", 32'(o_fifo_adr), 32'h2);
		check_value("o_fd", 32'(o_fd), 32'h0);
		repeat (DECIM) drive_cycle(1'b1);
		check_value("words before first group", 32'(words_seen - words_at_start), 32'h0);
		t = 0;
		while (words_seen == words_at_start && t < 100) begin
			drive_cycle(1'b1);
			t++;
		end
		if (words_seen == words_at_start) begin
			$display("timeout, no word written after the first group");
			chk_errors++;
		end
		finish_test("reset");

		// tuning word still 0 so Q stays zero
		start_test();
		repeat (400) drive_cycle(1'b1);
		wait_caught_up();
		finish_test("zero frequency");

		start_test();
		load_freq($random(seed));
		repeat (300) drive_cycle(1'b1);
		load_freq($random(seed));
		repeat (300) drive_cycle(1'b1);
		wait_caught_up();
		finish_test("tuned");

		start_test();
		load_freq($random(seed));
		repeat (600) drive_cycle(($random(seed) & 3) != 0);	// full about a quarter
		wait_caught_up();
		check_value("o_overflow", 32'(o_overflow), 32'h0);
		finish_test("flag toggle");

		// endpoint full long enough to fill the FIFO and drop pairs
		start_test();
		repeat (200) drive_cycle(1'b0);
		check_value("o_overflow", 32'(o_overflow), 32'h1);
		word_limit = words_seen + 2 * FIFO_DEPTH;
		t = 0;
		while (words_seen < word_limit && t < 400) begin
			drive_cycle(1'b1);
			t++;
		end
		if (words_seen < word_limit) begin
			$display("timeout, buffered pairs not delivered after release");
			chk_errors++;
		end
		apply_reset();
		check_value("o_overflow", 32'(o_overflow), 32'h0);
		finish_test("overflow");

		$display("%0d tests, %0d failed, %0d errors, %0d words", tests_run, tests_failed,
			mon_errors + chk_errors, words_seen);
		if (mon_errors + chk_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* src.f */
ddc_pkg.sv
fx2_pkg.sv
nco_mixer.sv
boxcar_decimator.sv
iq_fifo.sv
ep6_writer.sv
ozy_rx_top.sv
tb_ozy_rx_sva.sv
tb_ozy_rx.sv

/* run.sh */
#!/bin/sh
# build the receive path with its testbench and run the regression
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ozy_rx -f src.f \
	-o sim_ozy_rx \
	&& ./obj_dir/sim_ozy_rx > sim.log 2>&1 \
	|| echo "Regression failed" >> sim.log
cat sim.log
if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0
